// File: include/rp_defs.svh
// acquisition board widths, register map and saturation constants
`ifndef RP_DEFS_SVH
`define RP_DEFS_SVH

// --------------------
// data path widths
`define RP_ADC_W        14            // adc and dac sample width
`define RP_SUM_W        15            // sample plus level, before saturation
`define RP_BUS_W        32            // bus data and address width

// --------------------
// bus address map
`define RP_REGIONS      8             // regions selected by addr 22:20
`define RP_REG_OFFS_W   20            // offset inside a region
`define RP_REGION_HK    0             // housekeeping region
`define RP_REGION_MIX   1             // output level region

// --------------------
// register offsets and fixed values
`define RP_HK_ID        32'hFEED0001  // id word at offset 0 of region 0
`define RP_HK_LED_OFFS  20'h30        // led register
`define RP_LVL_A_OFFS   20'h00        // level channel a
`define RP_LVL_B_OFFS   20'h04        // level channel b

// saturation codes for the 14-bit two's complement result
`define RP_SAT_POS      14'h1FFF      // largest positive sample
`define RP_SAT_NEG      14'h2000      // most negative sample

`endif

// File: source/rp_pkg.sv
// rp_pkg shared sample, sum, bus word and address types
`default_nettype none

`include "rp_defs.svh"

package rp_pkg;

  localparam int REGION_W = $clog2(`RP_REGIONS);  // 3 bits for 8 regions

  // --------------------
  // data path words
  typedef logic signed [`RP_ADC_W-1:0] sample_t;  // two's complement sample
  typedef logic signed [`RP_SUM_W-1:0] sum_t;     // sum with one guard bit

  // --------------------
  // bus words
  typedef logic [`RP_BUS_W-1:0] bus_word_t;       // data or raw address
  typedef logic [REGION_W-1:0]  region_t;         // region index

  // field view of a bus address
  typedef struct packed {
    logic [`RP_BUS_W-REGION_W-`RP_REG_OFFS_W-1:0] rsvd;  // bits 31:23, ignored
    region_t                                      region;  // bits 22:20
    logic [`RP_REG_OFFS_W-1:0]                    offs;    // bits 19:0
  } sys_addr_fld_t;

  // one address word, seen raw or split in fields
  typedef union packed {
    bus_word_t     raw;  // as driven by the bus master
    sys_addr_fld_t fld;  // region and offset
  } sys_addr_u;

endpackage

`default_nettype wire

// File: source/adc_frontend.sv
// adc_frontend registers both raw adc buses and converts them to two's complement
`timescale 1ns/1ps
`default_nettype none

`include "rp_defs.svh"

module adc_frontend (
  input  logic                 adc_clk,      // sample clock
  input  logic                 rst_i,        // sync reset, active high
  input  logic [`RP_ADC_W-1:0] adc_dat_a_i,  // raw ch a, offset binary
  input  logic [`RP_ADC_W-1:0] adc_dat_b_i,  // raw ch b, offset binary
  output rp_pkg::sample_t      adc_a_o,      // ch a, two's complement
  output rp_pkg::sample_t      adc_b_o       // ch b, two's complement
);

  // --------------------
  // conversion
  // the adc has an inverted slope, so offset binary turns into two's
  // complement by keeping the msb and flipping the remaining bits

  logic [`RP_ADC_W-1:0] conv_a;  // converted, before the pin register
  logic [`RP_ADC_W-1:0] conv_b;

  assign conv_a = {adc_dat_a_i[`RP_ADC_W-1], ~adc_dat_a_i[`RP_ADC_W-2:0]};  // msb kept
  assign conv_b = {adc_dat_b_i[`RP_ADC_W-1], ~adc_dat_b_i[`RP_ADC_W-2:0]};  // msb kept

  // --------------------
  // pin register

  always_ff @(posedge adc_clk) begin
    if (rst_i) begin
      adc_a_o <= '0;  // zero sample until first capture
      adc_b_o <= '0;
    end else begin
      adc_a_o <= conv_a;  // single stage at the pins
      adc_b_o <= conv_b;
    end
  end

endmodule

`default_nettype wire

// File: source/sys_bus_decoder.sv
// sys_bus_decoder splits the bus into 8 regions and muxes the responses back
`timescale 1ns/1ps
`default_nettype none

`include "rp_defs.svh"

module sys_bus_decoder (
  input  logic              adc_clk,      // bus runs on the adc clock
  input  logic              rst_i,        // sync reset, active high
  input  rp_pkg::sys_addr_u sys_addr_i,   // bus address
  input  logic              sys_wen_i,    // write strobe, one cycle
  input  logic              sys_ren_i,    // read strobe, one cycle
  output logic              hk_wen_o,     // region 0 write
  output logic              hk_ren_o,     // region 0 read
  input  rp_pkg::bus_word_t hk_rdata_i,   // region 0 read data
  input  logic              hk_ack_i,     // region 0 ack
  output logic              mix_wen_o,    // region 1 write
  output logic              mix_ren_o,    // region 1 read
  input  rp_pkg::bus_word_t mix_rdata_i,  // region 1 read data
  input  logic              mix_ack_i,    // region 1 ack
  output rp_pkg::bus_word_t sys_rdata_o,  // read data to master
  output logic              sys_ack_o,    // ack to master
  output logic              sys_err_o     // error to master
);

  import rp_pkg::*;

  logic [`RP_REGIONS-1:0] region_sel;  // one-hot region of current address
  logic                   strobe;      // any access this cycle
  logic                   unmapped;    // address hits regions 2..7
  region_t                region_q;    // region latched at strobe
  logic                   err_ack_q;   // own response for unmapped access

  // --------------------
  // region decode
  assign region_sel = `RP_REGIONS'(1) << sys_addr_i.fld.region;  // one-hot
  assign strobe     = sys_wen_i | sys_ren_i;
  assign unmapped   = |region_sel[`RP_REGIONS-1:`RP_REGION_MIX+1];  // nobody home

  assign hk_wen_o  = sys_wen_i & region_sel[`RP_REGION_HK];   // gated strobes
  assign hk_ren_o  = sys_ren_i & region_sel[`RP_REGION_HK];
  assign mix_wen_o = sys_wen_i & region_sel[`RP_REGION_MIX];
  assign mix_ren_o = sys_ren_i & region_sel[`RP_REGION_MIX];

  // --------------------
  // access tracking
  always_ff @(posedge adc_clk) begin
    if (rst_i) begin
      region_q  <= region_t'(`RP_REGION_HK);
      err_ack_q <= 1'b0;
    end else begin
      if (strobe)
        region_q <= sys_addr_i.fld.region;  // held until next access
      err_ack_q <= strobe & unmapped;       // answer one cycle later
    end
  end

  // response mux, selected by the latched region
  always_comb begin
    case (region_q)
      region_t'(`RP_REGION_HK): begin
        sys_rdata_o = hk_rdata_i;
        sys_ack_o   = hk_ack_i;
        sys_err_o   = 1'b0;
      end
      region_t'(`RP_REGION_MIX): begin
        sys_rdata_o = mix_rdata_i;
        sys_ack_o   = mix_ack_i;
        sys_err_o   = 1'b0;
      end
      default: begin
        sys_rdata_o = '0;         // unmapped reads give zero
        sys_ack_o   = err_ack_q;
        sys_err_o   = err_ack_q;  // flagged as error
      end
    endcase
  end

  // --------------------
  // checks
  a_one_ack: assert property (@(posedge adc_clk) disable iff (rst_i)
    !(hk_ack_i && mix_ack_i));  // only one region answers at a time
  a_one_strobe: assert property (@(posedge adc_clk) disable iff (rst_i)
    !(sys_wen_i && sys_ren_i));  // master never reads and writes together

endmodule

`default_nettype wire

// File: source/hk_regs.sv
// hk_regs housekeeping region with the id word and the led register
`timescale 1ns/1ps
`default_nettype none

`include "rp_defs.svh"

module hk_regs (
  input  logic                      adc_clk,     // clock
  input  logic                      rst_i,       // sync reset, active high
  input  logic [`RP_REG_OFFS_W-1:0] reg_offs_i,  // offset in region 0
  input  rp_pkg::bus_word_t         wdata_i,     // write data
  input  logic                      wen_i,       // write strobe
  input  logic                      ren_i,       // read strobe
  output rp_pkg::bus_word_t         rdata_o,     // read data, registered
  output logic                      ack_o,       // ack, one cycle after strobe
  output logic [7:0]                led_o        // led drive
);

  // --------------------
  // led register
  always_ff @(posedge adc_clk) begin
    if (rst_i) begin
      led_o <= '0;  // leds off
    end else if (wen_i && reg_offs_i == `RP_HK_LED_OFFS) begin
      led_o <= wdata_i[7:0];  // low byte only
    end
  end

  // --------------------
  // bus response
  always_ff @(posedge adc_clk) begin
    if (rst_i)
      ack_o <= 1'b0;
    else
      ack_o <= wen_i | ren_i;  // writes are acked too
  end

  // read data needs no reset, it is only looked at with ack
  always_ff @(posedge adc_clk) begin
    if (ren_i) begin
      case (reg_offs_i)
        `RP_REG_OFFS_W'(0): rdata_o <= `RP_HK_ID;               // id word
        `RP_HK_LED_OFFS:    rdata_o <= {{(`RP_BUS_W-8){1'b0}}, led_o};  // led
        default:            rdata_o <= '0;                      // hole in map
      endcase
    end
  end

endmodule

`default_nettype wire

// File: source/dac_mixer.sv
// dac_mixer output level registers and saturating sum of adc sample and level
`timescale 1ns/1ps
`default_nettype none

`include "rp_defs.svh"

module dac_mixer (
  input  logic                      adc_clk,     // clock
  input  logic                      rst_i,       // sync reset, active high
  input  logic [`RP_REG_OFFS_W-1:0] reg_offs_i,  // offset in region 1
  input  rp_pkg::bus_word_t         wdata_i,     // write data
  input  logic                      wen_i,       // write strobe
  input  logic                      ren_i,       // read strobe
  output rp_pkg::bus_word_t         rdata_o,     // read data, registered
  output logic                      ack_o,       // ack, one cycle after strobe
  input  rp_pkg::sample_t           adc_a_i,     // adc ch a
  input  rp_pkg::sample_t           adc_b_i,     // adc ch b
  output rp_pkg::sample_t           mix_a_o,     // saturated ch a
  output rp_pkg::sample_t           mix_b_o      // saturated ch b
);

  import rp_pkg::*;

  sample_t lvl_a_q;  // output level ch a
  sample_t lvl_b_q;  // output level ch b
  sum_t    sum_a;    // full sums, one guard bit
  sum_t    sum_b;

  // clip a 15-bit sum to 14 bits
  // the two top bits differ only when the sum left the 14-bit range
  function automatic sample_t sat(input sum_t s);
    case (s[`RP_SUM_W-1:`RP_SUM_W-2])
      2'b01:   sat = `RP_SAT_POS;         // positive overflow
      2'b10:   sat = `RP_SAT_NEG;         // negative overflow
      default: sat = s[`RP_ADC_W-1:0];    // in range, drop guard bit
    endcase
  endfunction

  // --------------------
  // level registers
  always_ff @(posedge adc_clk) begin
    if (rst_i) begin
      lvl_a_q <= '0;  // no offset after reset
      lvl_b_q <= '0;
    end else if (wen_i) begin
      if (reg_offs_i == `RP_LVL_A_OFFS)
        lvl_a_q <= wdata_i[`RP_ADC_W-1:0];  // low 14 bits, signed
      if (reg_offs_i == `RP_LVL_B_OFFS)
        lvl_b_q <= wdata_i[`RP_ADC_W-1:0];
    end
  end

  always_ff @(posedge adc_clk) begin
    if (rst_i)
      ack_o <= 1'b0;
    else
      ack_o <= wen_i | ren_i;
  end

  always_ff @(posedge adc_clk) begin
    if (ren_i) begin
      case (reg_offs_i)
        `RP_LVL_A_OFFS: rdata_o <= {{(`RP_BUS_W-`RP_ADC_W){lvl_a_q[`RP_ADC_W-1]}}, lvl_a_q};
        `RP_LVL_B_OFFS: rdata_o <= {{(`RP_BUS_W-`RP_ADC_W){lvl_b_q[`RP_ADC_W-1]}}, lvl_b_q};
        default:        rdata_o <= '0;  // unused offsets read zero
      endcase
    end
  end

  // --------------------
  // mixing
  assign sum_a = sum_t'(adc_a_i) + sum_t'(lvl_a_q);  // sign extended operands
  assign sum_b = sum_t'(adc_b_i) + sum_t'(lvl_b_q);

  always_ff @(posedge adc_clk) begin
    if (rst_i) begin
      mix_a_o <= '0;
      mix_b_o <= '0;
    end else begin
      mix_a_o <= sat(sum_a);  // one stage after the adc sample
      mix_b_o <= sat(sum_b);
    end
  end

  // an overflowing sum must come out as the matching limit next cycle
  a_sat_a: assert property (@(posedge adc_clk) disable iff (rst_i)
    (sum_a[`RP_SUM_W-1] != sum_a[`RP_SUM_W-2]) |=>
    (mix_a_o == ($past(sum_a[`RP_SUM_W-1]) ? `RP_SAT_NEG : `RP_SAT_POS)));
  a_sat_b: assert property (@(posedge adc_clk) disable iff (rst_i)
    (sum_b[`RP_SUM_W-1] != sum_b[`RP_SUM_W-2]) |=>
    (mix_b_o == ($past(sum_b[`RP_SUM_W-1]) ? `RP_SAT_NEG : `RP_SAT_POS)));

endmodule

`default_nettype wire

// File: source/dac_interleave.sv
// dac_interleave converts both channels to dac code and alternates them on one port
`timescale 1ns/1ps
`default_nettype none

`include "rp_defs.svh"

module dac_interleave (
  input  logic                 adc_clk,    // clock
  input  logic                 rst_i,      // sync reset, active high
  input  rp_pkg::sample_t      mix_a_i,    // ch a sample
  input  rp_pkg::sample_t      mix_b_i,    // ch b sample
  output logic [`RP_ADC_W-1:0] dac_dat_o,  // shared dac data bus
  output logic                 dac_sel_o,  // 0 ch a, 1 ch b
  output logic                 dac_wrt_o   // dac write
);

  logic                 phase_q;   // 0 sends a, 1 sends b
  logic [`RP_ADC_W-1:0] code_a;    // dac codes of the inputs
  logic [`RP_ADC_W-1:0] code_b;
  logic [`RP_ADC_W-1:0] code_b_q;  // b held for the second slot

  // --------------------
  // sample to dac code, same rule as the adc side
  assign code_a = {mix_a_i[`RP_ADC_W-1], ~mix_a_i[`RP_ADC_W-2:0]};
  assign code_b = {mix_b_i[`RP_ADC_W-1], ~mix_b_i[`RP_ADC_W-2:0]};

  // --------------------
  // channel slots
  always_ff @(posedge adc_clk) begin
    if (rst_i) begin
      phase_q   <= 1'b0;
      dac_dat_o <= `RP_ADC_W'h1FFF;  // code of a zero sample
      dac_sel_o <= 1'b0;
      dac_wrt_o <= 1'b0;             // quiet until reset is released
    end else begin
      phase_q   <= ~phase_q;
      dac_wrt_o <= 1'b1;             // stays high from here on
      if (!phase_q) begin
        dac_dat_o <= code_a;         // both channels taken at once
        dac_sel_o <= 1'b0;
      end else begin
        dac_dat_o <= code_b_q;       // b from the same pair
        dac_sel_o <= 1'b1;
      end
    end
  end

  always_ff @(posedge adc_clk) begin
    if (!phase_q)
      code_b_q <= code_b;  // latch b with a
  end

  // the dac expects a and b strictly alternating while writing
  a_sel_toggle: assert property (@(posedge adc_clk) disable iff (rst_i)
    dac_wrt_o |=> (dac_sel_o != $past(dac_sel_o)));

endmodule

`default_nettype wire

// File: source/rp_top.sv
// rp_top two-channel acquisition and generation data path with its control bus
`timescale 1ns/1ps
`default_nettype none

`include "rp_defs.svh"

module rp_top (
  input  logic                 adc_clk,      // adc sample clock, also bus clock
  input  logic                 rst_i,        // sync reset, active high

  // adc
  input  logic [`RP_ADC_W-1:0] adc_dat_a_i,  // raw ch a
  input  logic [`RP_ADC_W-1:0] adc_dat_b_i,  // raw ch b

  // system bus
  input  rp_pkg::sys_addr_u    sys_addr_i,   // address
  input  rp_pkg::bus_word_t    sys_wdata_i,  // write data
  input  logic                 sys_wen_i,    // write strobe
  input  logic                 sys_ren_i,    // read strobe
  output rp_pkg::bus_word_t    sys_rdata_o,  // read data
  output logic                 sys_ack_o,    // ack
  output logic                 sys_err_o,    // error

  // dac
  output logic [`RP_ADC_W-1:0] dac_dat_o,    // shared dac data
  output logic                 dac_sel_o,    // channel select
  output logic                 dac_wrt_o,    // write

  output logic [7:0]           led_o         // leds
);

  import rp_pkg::*;

  sample_t   adc_a;      // converted adc samples
  sample_t   adc_b;
  sample_t   mix_a;      // saturated dac samples
  sample_t   mix_b;
  logic      hk_wen;     // region 0 strobes and response
  logic      hk_ren;
  bus_word_t hk_rdata;
  logic      hk_ack;
  logic      mix_wen;    // region 1 strobes and response
  logic      mix_ren;
  bus_word_t mix_rdata;
  logic      mix_ack;

  // --------------------
  // input side
  adc_frontend i_adc (
    .adc_clk     (adc_clk),
    .rst_i       (rst_i),
    .adc_dat_a_i (adc_dat_a_i),
    .adc_dat_b_i (adc_dat_b_i),
    .adc_a_o     (adc_a),
    .adc_b_o     (adc_b)
  );

  // --------------------
  // bus decode
  sys_bus_decoder i_dec (
    .adc_clk     (adc_clk),
    .rst_i       (rst_i),
    .sys_addr_i  (sys_addr_i),
    .sys_wen_i   (sys_wen_i),
    .sys_ren_i   (sys_ren_i),
    .hk_wen_o    (hk_wen),
    .hk_ren_o    (hk_ren),
    .hk_rdata_i  (hk_rdata),
    .hk_ack_i    (hk_ack),
    .mix_wen_o   (mix_wen),
    .mix_ren_o   (mix_ren),
    .mix_rdata_i (mix_rdata),
    .mix_ack_i   (mix_ack),
    .sys_rdata_o (sys_rdata_o),
    .sys_ack_o   (sys_ack_o),
    .sys_err_o   (sys_err_o)
  );

  // --------------------
  // housekeeping, region 0
  hk_regs i_hk (
    .adc_clk    (adc_clk),
    .rst_i      (rst_i),
    .reg_offs_i (sys_addr_i.fld.offs),  // offset view of the address
    .wdata_i    (sys_wdata_i),
    .wen_i      (hk_wen),
    .ren_i      (hk_ren),
    .rdata_o    (hk_rdata),
    .ack_o      (hk_ack),
    .led_o      (led_o)
  );

  // --------------------
  // processing, region 1
  dac_mixer i_mix (
    .adc_clk    (adc_clk),
    .rst_i      (rst_i),
    .reg_offs_i (sys_addr_i.fld.offs),
    .wdata_i    (sys_wdata_i),
    .wen_i      (mix_wen),
    .ren_i      (mix_ren),
    .rdata_o    (mix_rdata),
    .ack_o      (mix_ack),
    .adc_a_i    (adc_a),   // direct adc path
    .adc_b_i    (adc_b),
    .mix_a_o    (mix_a),
    .mix_b_o    (mix_b)
  );

  // --------------------
  // output side
  dac_interleave i_dac (
    .adc_clk   (adc_clk),
    .rst_i     (rst_i),
    .mix_a_i   (mix_a),
    .mix_b_i   (mix_b),
    .dac_dat_o (dac_dat_o),
    .dac_sel_o (dac_sel_o),
    .dac_wrt_o (dac_wrt_o)
  );

endmodule

`default_nettype wire

// File: sim/tb_rp_top.sv
// tb_rp_top self-checking testbench for the acquisition data path and its control bus
`timescale 1ns/1ps
`default_nettype none

`include "rp_defs.svh"

module tb_rp_top;

  import rp_pkg::*;

  localparam int RST_CYC     = 10;  // reset length in clocks
  localparam int ACK_TIMEOUT = 20;  // clocks to wait for a bus ack
  localparam int SLOT_TIMEOUT = 20; // clocks to wait for a dac slot
  localparam int SETTLE_CYC  = 8;   // adc to dac pipeline with margin
  localparam int RAND_RUNS   = 8;   // random level and sample sets

  logic                 adc_clk;
  logic                 rst;
  logic [`RP_ADC_W-1:0] adc_dat_a;   // raw adc codes
  logic [`RP_ADC_W-1:0] adc_dat_b;
  sys_addr_u            sys_addr;
  bus_word_t            sys_wdata;
  logic                 sys_wen;
  logic                 sys_ren;
  bus_word_t            sys_rdata;
  logic                 sys_ack;
  logic                 sys_err;
  logic [`RP_ADC_W-1:0] dac_dat;
  logic                 dac_sel;
  logic                 dac_wrt;
  logic [7:0]           led;

  integer               seed = 32'h66e6;  // $random seed
  int                   value_errs = 0;   // wrong values seen
  int                   timeout_errs = 0; // waits that ran out
  logic [`RP_ADC_W-1:0] raw_a;            // current stimulus
  logic [`RP_ADC_W-1:0] raw_b;
  sample_t              lvl_a;            // levels last written
  sample_t              lvl_b;

  rp_top i_rp_top (
    .adc_clk     (adc_clk),
    .rst_i       (rst),
    .adc_dat_a_i (adc_dat_a),
    .adc_dat_b_i (adc_dat_b),
    .sys_addr_i  (sys_addr),
    .sys_wdata_i (sys_wdata),
    .sys_wen_i   (sys_wen),
    .sys_ren_i   (sys_ren),
    .sys_rdata_o (sys_rdata),
    .sys_ack_o   (sys_ack),
    .sys_err_o   (sys_err),
    .dac_dat_o   (dac_dat),
    .dac_sel_o   (dac_sel),
    .dac_wrt_o   (dac_wrt),
    .led_o       (led)
  );

  initial begin
    adc_clk = 1'b0;
    forever #4 adc_clk = ~adc_clk;  // 8 ns period
  end

  // --------------------
  // reference model
  // inverted slope offset binary keeps the msb and flips the rest
  function automatic sample_t adc_to_s(input logic [`RP_ADC_W-1:0] raw);
    return sample_t'(raw ^ {1'b0, {(`RP_ADC_W-1){1'b1}}});
  endfunction

  function automatic sample_t sat_sum(input sample_t s, input sample_t lvl);
    int total;
    total = int'(s) + int'(lvl);                  // exact sum without wrap
    if (total > (1 << (`RP_ADC_W-1)) - 1)
      total = (1 << (`RP_ADC_W-1)) - 1;           // clip high
    else if (total < -(1 << (`RP_ADC_W-1)))
      total = -(1 << (`RP_ADC_W-1));              // clip low
    return sample_t'(total);
  endfunction

  function automatic logic [`RP_ADC_W-1:0] s_to_dac(input sample_t s);
    return s ^ {1'b0, {(`RP_ADC_W-1){1'b1}}};    // same rule as the adc side
  endfunction

  function automatic bus_word_t sext(input sample_t s);
    int v;
    v = s;                                        // widen with sign
    return bus_word_t'(v);
  endfunction

  function automatic bus_word_t region_addr(input region_t r, input logic [19:0] offs);
    return {9'd0, r, offs};                       // bits 22:20 pick the region
  endfunction

  // --------------------
  // comparators
  task automatic check_word(input string name, input bus_word_t exp, input bus_word_t act);
    if (exp !== act) begin
      $display("Fail %s: expected %h, actual %h", name, exp, act);
      value_errs++;
    end
  endtask

  task automatic check_sample(input string name, input logic [`RP_ADC_W-1:0] exp,
                              input logic [`RP_ADC_W-1:0] act);
    if (exp !== act) begin
      $display("Fail %s: expected %h, actual %h", name, exp, act);
      value_errs++;
    end
  endtask

  // --------------------
  // bus access
  task automatic wait_ack(input string what);
    int n;
    n = 0;
    @(negedge adc_clk);
    while (!sys_ack && n < ACK_TIMEOUT) begin
      @(negedge adc_clk);
      n++;
    end
    if (!sys_ack) begin
      $display("timeout: the bus never acknowledged the %s", what);
      timeout_errs++;
    end
  endtask

  task automatic bus_write(input bus_word_t addr, input bus_word_t data, output logic err);
    @(posedge adc_clk);
    sys_addr  <= addr;
    sys_wdata <= data;
    sys_wen   <= 1'b1;                            // one-cycle strobe
    @(posedge adc_clk);
    sys_wen   <= 1'b0;
    wait_ack($sformatf("write to %h", addr));
    err = sys_err;
  endtask

  task automatic bus_read(input bus_word_t addr, output bus_word_t data, output logic err);
    @(posedge adc_clk);
    sys_addr <= addr;
    sys_ren  <= 1'b1;
    @(posedge adc_clk);
    sys_ren  <= 1'b0;
    wait_ack($sformatf("read from %h", addr));
    data = sys_rdata;                             // valid with ack
    err  = sys_err;
  endtask

  // --------------------
  // data path helpers
  task automatic apply_levels(input sample_t a, input sample_t b);
    logic err;
    bus_write(region_addr(3'd1, `RP_LVL_A_OFFS), sext(a), err);
    check_word("level a write err", '0, bus_word_t'(err));
    bus_write(region_addr(3'd1, `RP_LVL_B_OFFS), sext(b), err);
    check_word("level b write err", '0, bus_word_t'(err));
  endtask

  task automatic drive_adc(input logic [`RP_ADC_W-1:0] a, input logic [`RP_ADC_W-1:0] b);
    @(posedge adc_clk);
    adc_dat_a <= a;
    adc_dat_b <= b;
  endtask

  task automatic wait_dac_slot(input logic sel, input string name);
    int n;
    n = 0;
    @(negedge adc_clk);
    while (!(dac_wrt && dac_sel == sel) && n < SLOT_TIMEOUT) begin
      @(negedge adc_clk);
      n++;
    end
    if (!(dac_wrt && dac_sel == sel)) begin
      $display("timeout: dac never sent channel %0d during %s", sel, name);
      timeout_errs++;
    end
  endtask

  task automatic compare_dac_slots(input string name, input logic [`RP_ADC_W-1:0] exp_a,
                                   input logic [`RP_ADC_W-1:0] exp_b);
    repeat (SETTLE_CYC) @(posedge adc_clk);      // let the new stimulus through
    wait_dac_slot(1'b0, name);
    check_sample({name, " ch a"}, exp_a, dac_dat);
    wait_dac_slot(1'b1, name);
    check_sample({name, " ch b"}, exp_b, dac_dat);
  endtask

  // --------------------
  // test sequence
  initial begin
    bus_word_t rdata;
    logic      err;
    rst       <= 1'b1;
    adc_dat_a <= '0;
    adc_dat_b <= '0;
    sys_addr  <= '0;
    sys_wdata <= '0;
    sys_wen   <= 1'b0;
    sys_ren   <= 1'b0;

    // reset state sampled in the last reset cycle
    repeat (RST_CYC - 1) @(posedge adc_clk);
    @(negedge adc_clk);
    check_word("reset dac_wrt_o", '0, bus_word_t'(dac_wrt));
    check_word("reset dac_sel_o", '0, bus_word_t'(dac_sel));
    check_word("reset sys_ack_o", '0, bus_word_t'(sys_ack));
    check_word("reset sys_err_o", '0, bus_word_t'(sys_err));
    check_word("reset led_o", '0, bus_word_t'(led));
    check_sample("reset dac_dat_o", s_to_dac('0), dac_dat);
    @(posedge adc_clk);
    rst <= 1'b0;

    bus_read(region_addr(3'd0, 20'h0), rdata, err);
    check_word("id word", `RP_HK_ID, rdata);
    check_word("id err", '0, bus_word_t'(err));

    // led register takes the low byte only
    bus_write(region_addr(3'd0, `RP_HK_LED_OFFS), 32'hA5A5_5A3C, err);
    check_word("led write err", '0, bus_word_t'(err));
    @(negedge adc_clk);
    check_word("led_o", 32'h3C, bus_word_t'(led));
    bus_read(region_addr(3'd0, `RP_HK_LED_OFFS), rdata, err);
    check_word("led readback", 32'h3C, rdata);

    // level readback with one negative and one positive value
    lvl_a = sample_t'(-300);
    lvl_b = sample_t'(1000);
    apply_levels(lvl_a, lvl_b);
    bus_read(region_addr(3'd1, `RP_LVL_A_OFFS), rdata, err);
    check_word("level a readback", sext(lvl_a), rdata);
    bus_read(region_addr(3'd1, `RP_LVL_B_OFFS), rdata, err);
    check_word("level b readback", sext(lvl_b), rdata);

    // random levels on constant random samples
    for (int i = 0; i < RAND_RUNS; i++) begin
      raw_a = 14'($random(seed));
      raw_b = 14'($random(seed));
      lvl_a = sample_t'($random(seed));
      lvl_b = sample_t'($random(seed));
      apply_levels(lvl_a, lvl_b);
      drive_adc(raw_a, raw_b);
      compare_dac_slots($sformatf("random %0d", i),
                        s_to_dac(sat_sum(adc_to_s(raw_a), lvl_a)),
                        s_to_dac(sat_sum(adc_to_s(raw_b), lvl_b)));
    end

    // full scale samples pushed further out into saturation
    lvl_a = sample_t'(8191);
    lvl_b = sample_t'(-8192);
    apply_levels(lvl_a, lvl_b);
    drive_adc(14'h0000, 14'h3FFF);               // most positive a and most negative b
    compare_dac_slots("saturate a pos b neg", s_to_dac(`RP_SAT_POS), s_to_dac(`RP_SAT_NEG));
    lvl_a = sample_t'(-8192);
    lvl_b = sample_t'(8191);
    apply_levels(lvl_a, lvl_b);
    drive_adc(14'h3FFF, 14'h0000);
    compare_dac_slots("saturate a neg b pos", s_to_dac(`RP_SAT_NEG), s_to_dac(`RP_SAT_POS));

    // unmapped regions answer with err and touch nothing
    for (int r = 2; r < `RP_REGIONS; r++) begin
      bus_write(region_addr(region_t'(r), `RP_HK_LED_OFFS), 32'hFFFF_FFFF, err);
      check_word($sformatf("region %0d led write err", r), 32'h1, bus_word_t'(err));
      bus_write(region_addr(region_t'(r), `RP_LVL_A_OFFS), 32'h0000_1234, err);
      check_word($sformatf("region %0d level a write err", r), 32'h1, bus_word_t'(err));
      bus_write(region_addr(region_t'(r), `RP_LVL_B_OFFS), 32'h0000_0567, err);
      check_word($sformatf("region %0d level b write err", r), 32'h1, bus_word_t'(err));
      bus_read(region_addr(region_t'(r), 20'h0), rdata, err);
      check_word($sformatf("region %0d read data", r), '0, rdata);
      check_word($sformatf("region %0d read err", r), 32'h1, bus_word_t'(err));
    end
    check_word("led_o after unmapped", 32'h3C, bus_word_t'(led));
    bus_read(region_addr(3'd0, `RP_HK_LED_OFFS), rdata, err);
    check_word("led after unmapped", 32'h3C, rdata);
    bus_read(region_addr(3'd1, `RP_LVL_A_OFFS), rdata, err);
    check_word("level a after unmapped", sext(lvl_a), rdata);
    bus_read(region_addr(3'd1, `RP_LVL_B_OFFS), rdata, err);
    check_word("level b after unmapped", sext(lvl_b), rdata);

    $display("errors: %0d value mismatches, %0d timeouts", value_errs, timeout_errs);
    if (value_errs == 0 && timeout_errs == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: list.f
+incdir+include
source/rp_pkg.sv
source/adc_frontend.sv
source/sys_bus_decoder.sv
source/hk_regs.sv
source/dac_mixer.sv
source/dac_interleave.sv
source/rp_top.sv
sim/tb_rp_top.sv

// File: run_sim.sh
#!/bin/sh
# build the rp_top testbench with Verilator, run it, and judge the log

verilator --binary --timing --assert --top-module tb_rp_top -f list.f \
  -Mdir obj_dir -o tb_rp_top > build.log 2>&1 \
  || { echo "build failed, see build.log"; exit 1; }

./obj_dir/tb_rp_top > sim.log 2>&1
cat sim.log

grep -q "=== FAIL ===" sim.log && { echo "simulation reported failure"; exit 1; }
grep -q "=== PASS ===" sim.log || { echo "simulation ended without a verdict"; exit 1; }
echo "simulation passed"
